// ==== bench/fabric_stimulus.txt ====
# op addr data strb exp_rdata exp_resp, all hex. W write, R read, C write issued with the next R
# Writes check exp_resp only, reads check exp_rdata and exp_resp
# Full-strobe write and read back
W 02000010 a5a51234 f 00000000 0
R 02000010 00000000 0 a5a51234 0
W 02000000 00c0ffee f 00000000 0
R 02000000 00000000 0 00c0ffee 0
# Partial strobes merge with the prior bytes
W 02000020 11223344 f 00000000 0
W 02000020 aabbccdd 5 00000000 0
R 02000020 00000000 0 11bb33dd 0
W 02000020 eeff0099 8 00000000 0
R 02000020 00000000 0 eebb33dd 0
W 02000024 00000000 f 00000000 0
W 02000024 12345678 2 00000000 0
R 02000024 00000000 0 00005600 0
W 02000024 cafef00d 0 00000000 0
R 02000024 00000000 0 00005600 0
W 02000024 9abcdef0 c 00000000 0
R 02000024 00000000 0 9abc5600 0
# Same word index in all four banks
W 02000014 10000001 f 00000000 0
W 02000414 20000002 f 00000000 0
W 02000814 30000003 f 00000000 0
W 02000c14 40000004 f 00000000 0
R 02000014 00000000 0 10000001 0
R 02000414 00000000 0 20000002 0
R 02000814 00000000 0 30000003 0
R 02000c14 00000000 0 40000004 0
# Top word of the window
W 02000ffc 0f0f0f0f f 00000000 0
R 02000ffc 00000000 0 0f0f0f0f 0
# Outside the window, in-window words with the same bank and word stay intact
W 03000414 deadbeef f 00000000 3
R 03000414 00000000 0 00000000 3
R 02000414 00000000 0 20000002 0
W 02001414 deadbeef f 00000000 3
R 02001414 00000000 0 00000000 3
W 01fffffc 12345678 f 00000000 3
R 01fffffc 00000000 0 00000000 3
R 02000414 00000000 0 20000002 0
R 02000ffc 00000000 0 0f0f0f0f 0
# Read and write accepted together, different banks
C 02000804 55aa55aa f 00000000 0
R 02000014 00000000 0 10000001 0
R 02000804 00000000 0 55aa55aa 0
C 02000c08 13572468 f 00000000 0
R 02000020 00000000 0 eebb33dd 0
R 02000c08 00000000 0 13572468 0
C 04000000 ffffffff f 00000000 3
R 02000ffc 00000000 0 0f0f0f0f 0
R 02000000 00000000 0 00c0ffee 0
C 02000100 01020304 f 00000000 0
R 05000000 00000000 0 00000000 3
R 02000100 00000000 0 01020304 0
R 02000c14 00000000 0 40000004 0

// ==== bench/fabric_tb.sv ====
// Memory fabric testbench, replays the stimulus file against the AXI-Lite port
`timescale 1ns/1ps

module fabric_tb;

	localparam int TIMEOUT_CYCLES = 50;
	localparam int RESP_LATENCY   = 3; // Accept edge to valid edge
	localparam int MAX_HOLD       = 5;

	logic                              hdmi_pixClk;
	logic                              rst;
	logic [fabric_pkg::ADDR_WIDTH-1:0] awaddr;
	logic                              awvalid;
	logic                              awready;
	logic [fabric_pkg::DATA_WIDTH-1:0] wdata;
	logic [fabric_pkg::STRB_WIDTH-1:0] wstrb;
	logic                              wvalid;
	logic                              wready;
	fabric_pkg::axil_resp_t            bresp;
	logic                              bvalid;
	logic                              bready;
	logic [fabric_pkg::ADDR_WIDTH-1:0] araddr;
	logic                              arvalid;
	logic                              arready;
	logic [fabric_pkg::DATA_WIDTH-1:0] rdata;
	fabric_pkg::axil_resp_t            rresp;
	logic                              rvalid;
	logic                              rready;

	mem_fabric UUT (
		.hdmi_pixClk(hdmi_pixClk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #20 hdmi_pixClk = ~hdmi_pixClk;
	end

	task automatic report_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s, gave up after %0d cycles", what, TIMEOUT_CYCLES);
		report_failure();
	endtask

	// Outputs are read and inputs driven 2 ns after the edge
	task automatic next_cycle();
		@(posedge hdmi_pixClk);
		#2;
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error: %s latency = %h cycles, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_wr_resp(input fabric_pkg::axil_resp_t got,
		input fabric_pkg::axil_resp_t exp);
		if (got !== exp) begin
			$display("Error: bresp = %h, expected %h", got, exp);
			report_failure();
		end
	endtask

	task automatic check_rd_resp(input fabric_pkg::rd_resp_t got, input fabric_pkg::rd_resp_t exp);
		if (got.data !== exp.data) begin
			$display("Error: rdata = %h, expected %h", got.data, exp.data);
			report_failure();
		end
		if (got.resp !== exp.resp) begin
			$display("Error: rresp = %h, expected %h", got.resp, exp.resp);
			report_failure();
		end
	endtask

	function automatic fabric_pkg::rd_resp_t rd_payload();
		fabric_pkg::rd_resp_t r;
		r.data = rdata;
		r.resp = rresp;
		return r;
	endfunction

	task automatic wait_accept(input logic want_wr, input logic want_rd);
		int n;
		n = 0;
		while ((want_wr && !(awready && wready)) || (want_rd && !arready)) begin
			next_cycle();
			n++;
			if (n >= TIMEOUT_CYCLES)
				report_timeout("the request ready");
		end
		next_cycle(); // Accepting edge
		if (want_wr) begin
			awvalid = 1'b0;
			wvalid  = 1'b0;
			check_flag("awready", awready, 1'b0);
			check_flag("wready", wready, 1'b0);
		end
		if (want_rd) begin
			arvalid = 1'b0;
			check_flag("arready", arready, 1'b0);
		end
	endtask

	// Edges from acceptance until each wanted valid shows up
	task automatic wait_response(input logic want_wr, input logic want_rd);
		int n;
		int b_at;
		int r_at;
		n = 0;
		b_at = -1;
		r_at = -1;
		while ((want_wr && b_at < 0) || (want_rd && r_at < 0)) begin
			next_cycle();
			n++;
			if (bvalid && b_at < 0)
				b_at = n;
			if (rvalid && r_at < 0)
				r_at = n;
			if (n >= TIMEOUT_CYCLES)
				report_timeout("the response valid");
		end
		if (want_wr)
			check_latency("bvalid", b_at, RESP_LATENCY);
		if (want_rd)
			check_latency("rvalid", r_at, RESP_LATENCY);
	endtask

	task automatic hold_responses(input int delay, input logic want_wr, input logic want_rd,
		input fabric_pkg::axil_resp_t b_exp, input fabric_pkg::rd_resp_t r_exp);
		for (int k = 0; k < delay; k++) begin
			next_cycle();
			if (want_wr) begin
				check_flag("bvalid", bvalid, 1'b1);
				check_wr_resp(bresp, b_exp);
				check_flag("awready", awready, 1'b0);
				check_flag("wready", wready, 1'b0);
			end
			if (want_rd) begin
				check_flag("rvalid", rvalid, 1'b1);
				check_rd_resp(rd_payload(), r_exp);
				check_flag("arready", arready, 1'b0);
			end
		end
	endtask

	task automatic release_responses(input logic want_wr, input logic want_rd);
		bready = want_wr;
		rready = want_rd;
		next_cycle(); // Response transfer
		bready = 1'b0;
		rready = 1'b0;
		if (want_wr) begin
			check_flag("bvalid", bvalid, 1'b0);
			check_flag("awready", awready, 1'b1);
			check_flag("wready", wready, 1'b1);
		end
		if (want_rd) begin
			check_flag("rvalid", rvalid, 1'b0);
			check_flag("arready", arready, 1'b1);
		end
	endtask

	task automatic run_transaction(input logic want_wr, input logic want_rd,
		input logic [fabric_pkg::ADDR_WIDTH-1:0] w_addr,
		input logic [fabric_pkg::DATA_WIDTH-1:0] w_data,
		input logic [fabric_pkg::STRB_WIDTH-1:0] w_strb,
		input fabric_pkg::axil_resp_t b_exp,
		input logic [fabric_pkg::ADDR_WIDTH-1:0] r_addr,
		input fabric_pkg::rd_resp_t r_exp);
		int delay;
		if (want_wr) begin
			awaddr  = w_addr;
			wdata   = w_data;
			wstrb   = w_strb;
			awvalid = 1'b1;
			wvalid  = 1'b1;
		end
		if (want_rd) begin
			araddr  = r_addr;
			arvalid = 1'b1;
		end
		wait_accept(want_wr, want_rd);
		wait_response(want_wr, want_rd);
		if (want_wr)
			check_wr_resp(bresp, b_exp);
		if (want_rd)
			check_rd_resp(rd_payload(), r_exp);
		delay = $urandom % (MAX_HOLD + 1); // Ready hold-off
		hold_responses(delay, want_wr, want_rd, b_exp, r_exp);
		release_responses(want_wr, want_rd);
	endtask

	initial begin
		int fd;
		int code;
		int ch;
		int ops;
		logic [7:0] op;
		logic [fabric_pkg::ADDR_WIDTH-1:0] addr;
		logic [fabric_pkg::DATA_WIDTH-1:0] data;
		logic [fabric_pkg::STRB_WIDTH-1:0] strb;
		logic [fabric_pkg::DATA_WIDTH-1:0] exp_data;
		logic [1:0] resp;
		logic have_pend;
		logic [fabric_pkg::ADDR_WIDTH-1:0] pend_addr;
		logic [fabric_pkg::DATA_WIDTH-1:0] pend_data;
		logic [fabric_pkg::STRB_WIDTH-1:0] pend_strb;
		fabric_pkg::axil_resp_t pend_resp;
		fabric_pkg::rd_resp_t r_exp;

		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		void'($urandom(32'h10d5));

		repeat (8) @(posedge hdmi_pixClk);
		#2;
		rst = 1'b0;
		check_flag("bvalid", bvalid, 1'b0);
		check_flag("rvalid", rvalid, 1'b0);
		check_flag("awready", awready, 1'b1);
		check_flag("wready", wready, 1'b1);
		check_flag("arready", arready, 1'b1);

		fd = $fopen("bench/fabric_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/fabric_stimulus.txt");
			report_failure();
		end
		ops = 0;
		have_pend = 1'b0;
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd); // Skip rest of comment line
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h", addr, data, strb, exp_data, resp);
				if (code != 5) begin
					$display("Stimulus line for operation %s has missing or bad fields", op);
					report_failure();
				end
				r_exp.data = exp_data;
				r_exp.resp = fabric_pkg::axil_resp_t'(resp);
				if (op == "W" && !have_pend) begin
					run_transaction(1'b1, 1'b0, addr, data, strb,
						fabric_pkg::axil_resp_t'(resp), '0, '0);
				end else if (op == "R" && have_pend) begin
					run_transaction(1'b1, 1'b1, pend_addr, pend_data, pend_strb,
						pend_resp, addr, r_exp);
					have_pend = 1'b0;
				end else if (op == "R") begin
					run_transaction(1'b0, 1'b1, '0, '0, '0,
						fabric_pkg::RESP_OKAY, addr, r_exp);
				end else if (op == "C" && !have_pend) begin
					pend_addr = addr; // Issued together with the next read
					pend_data = data;
					pend_strb = strb;
					pend_resp = fabric_pkg::axil_resp_t'(resp);
					have_pend = 1'b1;
				end else begin
					$display("Stimulus file has an unexpected operation %s", op);
					report_failure();
				end
				ops++;
			end
		end
		$fclose(fd);

		if (have_pend || ops == 0) begin
			if (have_pend)
				$display("The last concurrent write in the stimulus file has no read after it");
			else
				$display("The stimulus file holds no operations");
			report_failure();
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// ==== hdl/fabric_decode.sv ====
// Fabric request decoder, accepts AXI-Lite requests and strobes the addressed RAM bank
`timescale 1ns/1ps

module fabric_decode (
	input  logic                                   hdmi_pixClk,
	input  logic                                   rst,
	input  logic [fabric_pkg::ADDR_WIDTH-1:0]      awaddr,
	input  logic                                   awvalid,
	output logic                                   awready,
	input  logic [fabric_pkg::DATA_WIDTH-1:0]      wdata,
	input  logic [fabric_pkg::STRB_WIDTH-1:0]      wstrb,
	input  logic                                   wvalid,
	output logic                                   wready,
	input  logic [fabric_pkg::ADDR_WIDTH-1:0]      araddr,
	input  logic                                   arvalid,
	output logic                                   arready,
	output fabric_pkg::wr_req_t                    wr_req,
	output fabric_pkg::rd_req_t                    rd_req,
	output logic [fabric_pkg::NUM_BANKS-1:0]       wr_stb,
	output logic [fabric_pkg::NUM_BANKS-1:0]       rd_stb,
	output logic                                   wr_err,
	output logic                                   rd_err,
	input  logic                                   wr_retire,
	input  logic                                   rd_retire
);

	logic wr_busy;
	logic rd_busy;
	logic wr_pend; // Captured request waiting for decode
	logic rd_pend;
	logic wr_accept;
	logic rd_accept;

	fabric_pkg::bus_addr_u                 wr_addr_q;
	fabric_pkg::bus_addr_u                 rd_addr_q;
	logic [fabric_pkg::DATA_WIDTH-1:0]     wr_data_q;
	logic [fabric_pkg::STRB_WIDTH-1:0]     wr_strb_q;

	// Address and data must arrive together
	assign wr_accept = awvalid & wvalid & ~wr_busy;
	assign rd_accept = arvalid & ~rd_busy;

	assign awready = ~wr_busy;
	assign wready  = ~wr_busy;
	assign arready = ~rd_busy;

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			wr_busy <= 1'b0;
			rd_busy <= 1'b0;
			wr_pend <= 1'b0;
			rd_pend <= 1'b0;
			wr_stb  <= '0;
			rd_stb  <= '0;
			wr_err  <= 1'b0;
			rd_err  <= 1'b0;
		end else begin
			wr_pend <= wr_accept;
			rd_pend <= rd_accept;
			if (wr_accept)
				wr_busy <= 1'b1;
			else if (wr_retire)
				wr_busy <= 1'b0;
			if (rd_accept)
				rd_busy <= 1'b1;
			else if (rd_retire)
				rd_busy <= 1'b0;

			wr_stb <= '0;
			rd_stb <= '0;
			wr_err <= 1'b0;
			rd_err <= 1'b0;
			if (wr_pend) begin
				if (wr_addr_q.fields.page == fabric_pkg::FABRIC_PAGE)
					wr_stb[wr_addr_q.fields.bank] <= 1'b1;
				else
					wr_err <= 1'b1; // Outside the window
			end
			if (rd_pend) begin
				if (rd_addr_q.fields.page == fabric_pkg::FABRIC_PAGE)
					rd_stb[rd_addr_q.fields.bank] <= 1'b1;
				else
					rd_err <= 1'b1;
			end
		end
	end

	// Request payload, captured on accept and handed to the banks one cycle later
	always_ff @(posedge hdmi_pixClk) begin
		if (wr_accept) begin
			wr_addr_q.raw <= awaddr;
			wr_data_q     <= wdata;
			wr_strb_q     <= wstrb;
		end
		if (rd_accept)
			rd_addr_q.raw <= araddr;
		if (wr_pend) begin
			wr_req.word <= wr_addr_q.fields.word;
			wr_req.data <= wr_data_q;
			wr_req.strb <= wr_strb_q;
		end
		if (rd_pend)
			rd_req.word <= rd_addr_q.fields.word;
	end

endmodule

// ==== hdl/fabric_pkg.sv ====
// Memory fabric shared types, sizes and AXI-Lite response codes
package fabric_pkg;

	localparam int ADDR_WIDTH     = 32;
	localparam int DATA_WIDTH     = 32;
	localparam int STRB_WIDTH     = 4;
	localparam int NUM_BANKS      = 4;
	localparam int BANK_WORDS     = 256;
	localparam int BANK_SEL_WIDTH = 2;
	localparam int WORD_IDX_WIDTH = 8;
	localparam int BYTE_OFF_WIDTH = 2;
	localparam int PAGE_WIDTH     = ADDR_WIDTH - BANK_SEL_WIDTH - WORD_IDX_WIDTH - BYTE_OFF_WIDTH;

	// Window 0x0200_0000 .. 0x0200_0FFF
	localparam logic [PAGE_WIDTH-1:0] FABRIC_PAGE = 20'h02000;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_DECERR = 2'd3
	} axil_resp_t;

	typedef struct packed {
		logic [PAGE_WIDTH-1:0]     page;
		logic [BANK_SEL_WIDTH-1:0] bank;
		logic [WORD_IDX_WIDTH-1:0] word;
		logic [BYTE_OFF_WIDTH-1:0] offset; // Ignored, word access only
	} bus_addr_fields_t;

	// Same 32 bits seen as a byte address or as decode fields
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		bus_addr_fields_t      fields;
	} bus_addr_u;

	typedef struct packed {
		logic [WORD_IDX_WIDTH-1:0] word;
		logic [DATA_WIDTH-1:0]     data;
		logic [STRB_WIDTH-1:0]     strb;
	} wr_req_t;

	typedef struct packed {
		logic [WORD_IDX_WIDTH-1:0] word;
	} rd_req_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		axil_resp_t            resp;
	} rd_resp_t;

endpackage

// ==== hdl/fabric_resp_merge.sv ====
// Response merger, collects bank acks and decode errors into AXI-Lite b and r responses
`timescale 1ns/1ps

module fabric_resp_merge (
	input  logic                                                    hdmi_pixClk,
	input  logic                                                    rst,
	input  logic [fabric_pkg::NUM_BANKS-1:0]                        wr_ack,
	input  logic [fabric_pkg::NUM_BANKS-1:0]                        rd_ack,
	input  logic [fabric_pkg::NUM_BANKS-1:0][fabric_pkg::DATA_WIDTH-1:0] rd_data,
	input  logic                                                    wr_err,
	input  logic                                                    rd_err,
	input  logic                                                    bready,
	input  logic                                                    rready,
	output fabric_pkg::axil_resp_t                                  bresp,
	output logic                                                    bvalid,
	output logic [fabric_pkg::DATA_WIDTH-1:0]                       rdata,
	output fabric_pkg::axil_resp_t                                  rresp,
	output logic                                                    rvalid,
	output logic                                                    wr_retire,
	output logic                                                    rd_retire
);

	logic wr_err_d; // Lines the error up with the bank ack
	logic rd_err_d;
	logic wr_done;
	logic rd_done;

	fabric_pkg::rd_resp_t rd_next;
	fabric_pkg::rd_resp_t rd_q;

	assign wr_done = (|wr_ack) | wr_err_d;
	assign rd_done = (|rd_ack) | rd_err_d;

	// Acks are one-hot, so an OR of masked data picks the bank
	always_comb begin
		rd_next.data = '0;
		rd_next.resp = fabric_pkg::RESP_OKAY;
		if (rd_err_d) begin
			rd_next.resp = fabric_pkg::RESP_DECERR;
		end else begin
			for (int i = 0; i < fabric_pkg::NUM_BANKS; i++) begin
				if (rd_ack[i])
					rd_next.data = rd_next.data | rd_data[i];
			end
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			wr_err_d <= 1'b0;
			rd_err_d <= 1'b0;
			bvalid   <= 1'b0;
			rvalid   <= 1'b0;
		end else begin
			wr_err_d <= wr_err;
			rd_err_d <= rd_err;
			if (wr_done)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_done)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Payload only loads on a new response, so it holds under back-pressure
	always_ff @(posedge hdmi_pixClk) begin
		if (wr_done) begin
			if (wr_err_d)
				bresp <= fabric_pkg::RESP_DECERR;
			else
				bresp <= fabric_pkg::RESP_OKAY;
		end
		if (rd_done)
			rd_q <= rd_next;
	end

	assign rdata = rd_q.data;
	assign rresp = rd_q.resp;

	assign wr_retire = bvalid & bready;
	assign rd_retire = rvalid & rready;

endmodule

// ==== hdl/mem_fabric.sv ====
// AXI-Lite memory fabric top, decoder feeding four RAM banks and a response merger
`timescale 1ns/1ps

module mem_fabric (
	input  logic                              hdmi_pixClk,
	input  logic                              rst,
	input  logic [fabric_pkg::ADDR_WIDTH-1:0] awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [fabric_pkg::DATA_WIDTH-1:0] wdata,
	input  logic [fabric_pkg::STRB_WIDTH-1:0] wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output fabric_pkg::axil_resp_t            bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  logic [fabric_pkg::ADDR_WIDTH-1:0] araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [fabric_pkg::DATA_WIDTH-1:0] rdata,
	output fabric_pkg::axil_resp_t            rresp,
	output logic                              rvalid,
	input  logic                              rready
);

	fabric_pkg::wr_req_t                                          wr_req;
	fabric_pkg::rd_req_t                                          rd_req;
	logic [fabric_pkg::NUM_BANKS-1:0]                             wr_stb;
	logic [fabric_pkg::NUM_BANKS-1:0]                             rd_stb;
	logic [fabric_pkg::NUM_BANKS-1:0]                             wr_ack;
	logic [fabric_pkg::NUM_BANKS-1:0]                             rd_ack;
	logic [fabric_pkg::NUM_BANKS-1:0][fabric_pkg::DATA_WIDTH-1:0] rd_data;
	logic                                                         wr_err;
	logic                                                         rd_err;
	logic                                                         wr_retire;
	logic                                                         rd_retire;

	fabric_decode u_decode (
		.hdmi_pixClk(hdmi_pixClk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.wr_req(wr_req),
		.rd_req(rd_req),
		.wr_stb(wr_stb),
		.rd_stb(rd_stb),
		.wr_err(wr_err),
		.rd_err(rd_err),
		.wr_retire(wr_retire),
		.rd_retire(rd_retire)
	);

	// Request buses are shared, the strobes pick the bank
	for (genvar i = 0; i < fabric_pkg::NUM_BANKS; i++) begin : g_bank
		ram_bank u_bank (
			.hdmi_pixClk(hdmi_pixClk),
			.rst(rst),
			.wr_req(wr_req),
			.wr_stb(wr_stb[i]),
			.rd_req(rd_req),
			.rd_stb(rd_stb[i]),
			.wr_ack(wr_ack[i]),
			.rd_ack(rd_ack[i]),
			.rd_data(rd_data[i])
		);
	end

	fabric_resp_merge u_merge (
		.hdmi_pixClk(hdmi_pixClk),
		.rst(rst),
		.wr_ack(wr_ack),
		.rd_ack(rd_ack),
		.rd_data(rd_data),
		.wr_err(wr_err),
		.rd_err(rd_err),
		.bready(bready),
		.rready(rready),
		.bresp(bresp),
		.bvalid(bvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.wr_retire(wr_retire),
		.rd_retire(rd_retire)
	);

endmodule

// ==== hdl/ram_bank.sv ====
// Single RAM bank, byte-strobed write port and registered read port
`timescale 1ns/1ps

module ram_bank (
	input  logic                              hdmi_pixClk,
	input  logic                              rst,
	input  fabric_pkg::wr_req_t               wr_req,
	input  logic                              wr_stb,
	input  fabric_pkg::rd_req_t               rd_req,
	input  logic                              rd_stb,
	output logic                              wr_ack,
	output logic                              rd_ack,
	output logic [fabric_pkg::DATA_WIDTH-1:0] rd_data
);

	logic [fabric_pkg::DATA_WIDTH-1:0] mem [fabric_pkg::BANK_WORDS];

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_stb) begin
			for (int b = 0; b < fabric_pkg::STRB_WIDTH; b++) begin
				if (wr_req.strb[b])
					mem[wr_req.word][b*8 +: 8] <= wr_req.data[b*8 +: 8];
			end
		end
		// Old contents on a same-cycle write
		if (rd_stb)
			rd_data <= mem[rd_req.word];
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (rst) begin
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end else begin
			wr_ack <= wr_stb;
			rd_ack <= rd_stb;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the memory fabric testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
	-f src.f \
	--top-module fabric_tb \
	-o fabric_sim

./obj_dir/fabric_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Run failed, see sim.log"
	exit 1
fi

echo "Run finished, see sim.log"
exit 0

// ==== src.f ====
hdl/fabric_pkg.sv
hdl/fabric_decode.sv
hdl/ram_bank.sv
hdl/fabric_resp_merge.sv
hdl/mem_fabric.sv
bench/fabric_tb.sv
